// File: verilog/ref_mem_defs.svh
`ifndef REF_MEM_DEFS_SVH
`define REF_MEM_DEFS_SVH

// bank geometry
`define REF_NUM_BANKS        32
`define REF_ROW_W            7

// preload phase
`define REF_BANKS_PER_GROUP  4
`define REF_NUM_GROUPS       8
`define REF_ROWS_PER_GROUP   96
`define REF_PRELOAD_LEN      768

// sub-area 1 sweep
`define REF_SA1_COLUMNS      7
`define REF_SA1_ROWS         24
`define REF_STALL_LO         7
`define REF_STALL_HI         19
`define REF_BLOCK_STEP       24
`define REF_SPLIT_STEP       8

// apb register offsets
`define REF_CTRL_ADDR        0
`define REF_STATUS_ADDR      4

`endif

// File: verilog/ref_bank_pkg.sv
`default_nettype none

`include "ref_mem_defs.svh"

package ref_bank_pkg;

	// one enable per ram bank
	typedef logic [`REF_NUM_BANKS-1:0] bank_mask_t;

	typedef logic [`REF_ROW_W-1:0] row_addr_t;

	// bank 0 sits in the lowest slot
	typedef row_addr_t [`REF_NUM_BANKS-1:0] bank_addr_vec_t;

	// rotation for the pe array, 0 to num_banks-1
	typedef logic [$clog2(`REF_NUM_BANKS)-1:0] shift_t;

	// bank group index during preload
	typedef logic [$clog2(`REF_NUM_GROUPS)-1:0] group_idx_t;

	// search column index, column 1 is index 0
	typedef logic [$clog2(`REF_SA1_COLUMNS)-1:0] col_idx_t;

	// row inside a 24-row half column
	typedef logic [$clog2(`REF_SA1_ROWS)-1:0] sweep_row_t;

endpackage

`default_nettype wire

// File: verilog/ref_ctrl_pkg.sv
`default_nettype none

package ref_ctrl_pkg;

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		PRELOAD = 2'd1,
		SEARCH  = 2'd2
	} phase_t;

	// status register layout
	typedef struct packed {
		logic [27:0] zero;
		phase_t      phase;
		logic        done;
		logic        busy;
	} status_t;

endpackage

`default_nettype wire

// File: verilog/ref_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "ref_mem_defs.svh"

module ref_apb_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [7:0]           paddr,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	output logic                 pslverr,
	input  ref_ctrl_pkg::phase_t phase,
	output logic                 start
);

	import ref_ctrl_pkg::*;

	logic    access;
	logic    ctrl_hit;
	logic    status_hit;
	logic    done_q;
	phase_t  phase_q;
	status_t status;

	assign access     = psel && penable;
	assign ctrl_hit   = (paddr == 8'(`REF_CTRL_ADDR));
	assign status_hit = (paddr == 8'(`REF_STATUS_ADDR));

	// no wait states
	assign pready  = 1'b1;
	assign pslverr = access && !ctrl_hit && !status_hit;

	// start is ignored unless idle
	assign start = access && pwrite && ctrl_hit && pwdata[0] && (phase == IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q <= IDLE;
			done_q  <= 1'b0;
		end else begin
			phase_q <= phase;
			if (start) begin
				done_q <= 1'b0;
			end else if (phase_q == SEARCH && phase != SEARCH) begin
				done_q <= 1'b1;
			end
		end
	end

	always_comb begin
		status       = '0;
		status.busy  = (phase != IDLE);
		status.done  = done_q;
		status.phase = phase;
	end

	// ctrl register reads back zero
	assign prdata = (access && !pwrite && status_hit) ? status : 32'd0;

endmodule

`default_nettype wire

// File: verilog/ref_phase_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ref_phase_fsm (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic                 preload_last,
	input  logic                 search_last,
	output ref_ctrl_pkg::phase_t phase
);

	import ref_ctrl_pkg::*;

	phase_t state_q;
	phase_t state_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (start) begin
					state_d = PRELOAD;
				end
			end
			PRELOAD: begin
				if (preload_last) begin
					state_d = SEARCH;
				end
			end
			SEARCH: begin
				// sweep done, back to idle
				if (search_last) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	assign phase = state_q;

endmodule

`default_nettype wire

// File: verilog/ref_preload_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "ref_mem_defs.svh"

module ref_preload_gen (
	input  logic                        clk,
	input  logic                        rst_n,
	input  ref_ctrl_pkg::phase_t        phase,
	output ref_bank_pkg::bank_mask_t    bank_sel,
	output logic                        wr_en,
	output ref_bank_pkg::bank_addr_vec_t wr_addr,
	output logic                        preload_last
);

	import ref_ctrl_pkg::*;
	import ref_bank_pkg::*;

	group_idx_t group_q;
	row_addr_t  row_q;
	logic       active;
	logic       group_end;

	assign active    = (phase == PRELOAD);
	assign group_end = (row_q == row_addr_t'(`REF_ROWS_PER_GROUP - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			group_q <= '0;
			row_q   <= '0;
		end else if (!active) begin
			group_q <= '0;
			row_q   <= '0;
		end else if (group_end) begin
			// group 7 wraps to 0 on the last row
			row_q   <= '0;
			group_q <= group_q + 1'b1;
		end else begin
			row_q <= row_q + 1'b1;
		end
	end

	assign wr_en = active;

	// four adjacent banks per group
	assign bank_sel = active ?
		bank_mask_t'({`REF_BANKS_PER_GROUP{1'b1}}) << (group_q * `REF_BANKS_PER_GROUP) : '0;

	always_comb begin
		for (int b = 0; b < `REF_NUM_BANKS; b++) begin
			wr_addr[b] = active ? row_q : '0;
		end
	end

	assign preload_last = active && group_end &&
		(group_q == group_idx_t'(`REF_NUM_GROUPS - 1));

endmodule

`default_nettype wire

// File: verilog/ref_search_rd_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "ref_mem_defs.svh"

module ref_search_rd_gen (
	input  logic                         clk,
	input  logic                         rst_n,
	input  ref_ctrl_pkg::phase_t         phase,
	output logic                         rd_en,
	output ref_bank_pkg::bank_addr_vec_t rd_addr,
	output ref_bank_pkg::shift_t         shift_value,
	output logic                         search_last
);

	import ref_ctrl_pkg::*;
	import ref_bank_pkg::*;

	col_idx_t   col_q;
	logic       half_q;
	sweep_row_t row_q;
	logic       hold_q;
	logic       active;
	logic       in_window;
	logic       row_end;
	logic [1:0] blk;
	shift_t     split;
	row_addr_t  base_row;

	assign active    = (phase == SEARCH);
	assign in_window = (row_q >= sweep_row_t'(`REF_STALL_LO)) &&
		(row_q <= sweep_row_t'(`REF_STALL_HI));
	assign row_end   = (row_q == sweep_row_t'(`REF_SA1_ROWS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_q  <= '0;
			half_q <= 1'b0;
			row_q  <= '0;
			hold_q <= 1'b0;
		end else if (!active) begin
			col_q  <= '0;
			half_q <= 1'b0;
			row_q  <= '0;
			hold_q <= 1'b0;
		end else if (in_window && !hold_q) begin
			// reuse row, present it once more
			hold_q <= 1'b1;
		end else begin
			hold_q <= 1'b0;
			if (row_end) begin
				row_q  <= '0;
				half_q <= ~half_q;
				if (half_q) begin
					col_q <= (col_q == col_idx_t'(`REF_SA1_COLUMNS - 1)) ? '0 : col_q + 1'b1;
				end
			end else begin
				row_q <= row_q + 1'b1;
			end
		end
	end

	// lane split grows by 8 banks per column, restarting every 4 columns
	assign split = shift_t'(col_q[1:0] * `REF_SPLIT_STEP);

	// 24-row block: column group plus sub-block half
	assign blk      = {1'b0, col_q[2]} + {1'b0, half_q};
	assign base_row = row_addr_t'(row_q) + row_addr_t'(blk * `REF_BLOCK_STEP);

	always_comb begin
		for (int b = 0; b < `REF_NUM_BANKS; b++) begin
			if (!active) begin
				rd_addr[b] = '0;
			end else if (b < split) begin
				// low banks already in the next block
				rd_addr[b] = base_row + row_addr_t'(`REF_BLOCK_STEP);
			end else begin
				rd_addr[b] = base_row;
			end
		end
	end

	assign rd_en       = active;
	assign shift_value = active ? split : '0;

	assign search_last = active && half_q && row_end &&
		(col_q == col_idx_t'(`REF_SA1_COLUMNS - 1));

endmodule

`default_nettype wire

// File: verilog/ref_mem_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module ref_mem_ctrl_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [7:0]                   paddr,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [31:0]                  pwdata,
	output logic [31:0]                  prdata,
	output logic                         pready,
	output logic                         pslverr,
	output ref_bank_pkg::bank_mask_t     bank_sel,
	output logic                         wr_en,
	output ref_bank_pkg::bank_addr_vec_t wr_addr,
	output logic                         rd_en,
	output ref_bank_pkg::bank_addr_vec_t rd_addr,
	output ref_bank_pkg::shift_t         shift_value
);

	import ref_ctrl_pkg::*;

	phase_t phase;
	logic   start;
	logic   preload_last;
	logic   search_last;

	// register access and start pulse
	ref_apb_regs i_ref_apb_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.phase   (phase),
		.start   (start)
	);

	ref_phase_fsm i_ref_phase_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.preload_last (preload_last),
		.search_last  (search_last),
		.phase        (phase)
	);

	// write side, active in preload only
	ref_preload_gen i_ref_preload_gen (
		.clk          (clk),
		.rst_n        (rst_n),
		.phase        (phase),
		.bank_sel     (bank_sel),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.preload_last (preload_last)
	);

	// read side, sub-area 1 sweep
	ref_search_rd_gen i_ref_search_rd_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.phase       (phase),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.shift_value (shift_value),
		.search_last (search_last)
	);

endmodule

`default_nettype wire

// File: tb/tb_ref_mem_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ref_mem_ctrl_sva (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     wr_en,
	input logic                     rd_en,
	input ref_bank_pkg::bank_mask_t bank_sel,
	input logic                     pready,
	input ref_ctrl_pkg::phase_t     phase
);

	import ref_ctrl_pkg::*;

	// failure count
	int assert_errors = 0;

	no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && rd_en))
		else begin
			assert_errors++;
			$error("wr_en and rd_en high in the same cycle");
		end

	sel_only_on_write: assert property (@(posedge clk) disable iff (!rst_n)
		!wr_en |-> (bank_sel == '0))
		else begin
			assert_errors++;
			$error("bank_sel nonzero while wr_en is low");
		end

	// slave never inserts wait states
	pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
		else begin
			assert_errors++;
			$error("pready dropped low");
		end

	no_idle_to_search: assert property (@(posedge clk) disable iff (!rst_n)
		(phase == IDLE) |=> (phase != SEARCH))
		else begin
			assert_errors++;
			$error("phase jumped from IDLE to SEARCH");
		end

endmodule

bind ref_mem_ctrl_top tb_ref_mem_ctrl_sva i_tb_ref_mem_ctrl_sva (
	.clk      (clk),
	.rst_n    (rst_n),
	.wr_en    (wr_en),
	.rd_en    (rd_en),
	.bank_sel (bank_sel),
	.pready   (pready),
	.phase    (phase)
);

`default_nettype wire

// File: tb/tb_ref_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ref_mem_defs.svh"

module tb_ref_mem_ctrl;

	import ref_bank_pkg::*;

	localparam int APB_TIMEOUT = 16;
	localparam int RUN_TIMEOUT = 4000;
	localparam int NUM_STEPS   = 6;
	// each half column has 24 rows plus 13 reuse repeats
	localparam int SWEEP_LEN   = `REF_SA1_COLUMNS * 2 *
		(`REF_SA1_ROWS + `REF_STALL_HI - `REF_STALL_LO + 1);

	logic           clk;
	logic           rst_n;
	logic [7:0]     paddr;
	logic           psel;
	logic           penable;
	logic           pwrite;
	logic [31:0]    pwdata;
	logic [31:0]    prdata;
	logic           pready;
	logic           pslverr;
	bank_mask_t     bank_sel;
	logic           wr_en;
	bank_addr_vec_t wr_addr;
	logic           rd_en;
	bank_addr_vec_t rd_addr;
	shift_t         shift_value;

	int    error_count = 0;
	int    pass_count = 0;
	int    fail_count = 0;
	int    err_mark;
	string cur_test;

	// register table of name, write, address, write data, read data and pslverr
	string       step_name  [NUM_STEPS] = '{"unmapped_read", "unmapped_write",
		"ctrl_write_no_start", "ctrl_readback", "status_write", "idle_status"};
	logic        step_write [NUM_STEPS] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
	logic [7:0]  step_addr  [NUM_STEPS] = '{8'h08, 8'h0c, 8'h00, 8'h00, 8'h04, 8'h04};
	logic [31:0] step_wdata [NUM_STEPS] = '{32'h0, 32'h1, 32'h2, 32'h0, 32'hffff_ffff, 32'h0};
	logic [31:0] step_rdata [NUM_STEPS] = '{32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
	logic        step_err   [NUM_STEPS] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

	ref_mem_ctrl_top i_ref_mem_ctrl_top (.*);

	always #50 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic check_value(input string what, input logic [255:0] expected,
		input logic [255:0] actual);
		if (expected !== actual) begin
			$display("mismatch in %s (%s): expected %0h actual %0h", cur_test, what, expected,
				actual);
			error_count++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_mark = error_count;
	endtask

	task automatic end_test();
		if (error_count == err_mark) begin
			$display("test %s ok", cur_test);
			pass_count++;
		end else begin
			$display("test %s failed with %0d errors", cur_test, error_count - err_mark);
			fail_count++;
		end
	endtask

	// setup then access phase with a mid-cycle sample
	task automatic apb_access(input string name, input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waited;
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		waited  = 0;
		@(negedge clk);
		while (!pready && waited < APB_TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		if (!pready) begin
			abort_run({"apb access got no pready: ", name});
		end else begin
			rdata = prdata;
			err   = pslverr;
			@(posedge clk);
			#1;
			psel    = 1'b0;
			penable = 1'b0;
			pwrite  = 1'b0;
		end
	endtask

	task automatic wait_idle(output int busy_cycles);
		busy_cycles = 0;
		@(negedge clk);
		while ((wr_en || rd_en) && busy_cycles < RUN_TIMEOUT) begin
			busy_cycles++;
			@(negedge clk);
		end
		if (wr_en || rd_en) abort_run("controller did not return to idle in time");
	endtask

	function automatic bank_addr_vec_t preload_addr(input int p);
		bank_addr_vec_t v;
		for (int b = 0; b < `REF_NUM_BANKS; b++) begin
			v[b] = row_addr_t'(p % `REF_ROWS_PER_GROUP);
		end
		return v;
	endfunction

	function automatic bank_addr_vec_t sweep_addr(input int k, input int h, input int r);
		bank_addr_vec_t v;
		int split;
		int base;
		split = (k % 4) * `REF_SPLIT_STEP;
		base  = `REF_BLOCK_STEP * (k / 4 + h);
		for (int b = 0; b < `REF_NUM_BANKS; b++) begin
			v[b] = (b < split) ? row_addr_t'(r + base + `REF_BLOCK_STEP) : row_addr_t'(r + base);
		end
		return v;
	endfunction

	task automatic check_preload();
		for (int p = 0; p < `REF_PRELOAD_LEN; p++) begin
			@(negedge clk);
			check_value("preload wr_en", 1, wr_en);
			check_value("preload rd_en", 0, rd_en);
			check_value("preload bank_sel", 32'hf << (4 * (p / `REF_ROWS_PER_GROUP)), bank_sel);
			check_value("preload wr_addr", preload_addr(p), wr_addr);
		end
	endtask

	task automatic check_search();
		int reps;
		for (int k = 0; k < `REF_SA1_COLUMNS; k++) begin
			for (int h = 0; h < 2; h++) begin
				for (int r = 0; r < `REF_SA1_ROWS; r++) begin
					// reuse window rows come twice
					reps = (r >= `REF_STALL_LO && r <= `REF_STALL_HI) ? 2 : 1;
					for (int n = 0; n < reps; n++) begin
						@(negedge clk);
						check_value("search rd_en", 1, rd_en);
						check_value("search wr_en", 0, wr_en);
						check_value("search rd_addr", sweep_addr(k, h, r), rd_addr);
						check_value("search shift", (k % 4) * `REF_SPLIT_STEP, shift_value);
					end
				end
			end
		end
	endtask

	initial begin
		#1_000_000;
		abort_run("simulation watchdog expired before the tests finished");
	end

	initial begin
		logic [31:0] rdata;
		logic        err;
		logic [31:0] side_rdata;
		logic        side_err;
		int          busy;
		clk     = 1'b0;
		rst_n   = 1'b0;
		paddr   = 8'h00;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = 32'h0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		begin_test("reset");
		@(negedge clk);
		check_value("bank_sel", 0, bank_sel);
		check_value("wr_en", 0, wr_en);
		check_value("wr_addr", 0, wr_addr);
		check_value("rd_en", 0, rd_en);
		check_value("rd_addr", 0, rd_addr);
		check_value("shift_value", 0, shift_value);
		apb_access("reset_status", 1'b0, 8'h04, 32'h0, rdata, err);
		check_value("status", 0, rdata);
		end_test();

		begin_test("register_table");
		for (int i = 0; i < NUM_STEPS; i++) begin
			apb_access(step_name[i], step_write[i], step_addr[i], step_wdata[i], rdata, err);
			check_value({step_name[i], " pslverr"}, step_err[i], err);
			if (!step_write[i]) check_value({step_name[i], " prdata"}, step_rdata[i], rdata);
		end
		@(negedge clk);
		check_value("wr_en after table", 0, wr_en);
		end_test();

		begin_test("first_run");
		apb_access("start", 1'b1, 8'h00, 32'h1, rdata, err);
		fork
			begin
				check_preload();
				check_search();
			end
			begin
				repeat (200) @(posedge clk);
				apb_access("start_in_preload", 1'b1, 8'h00, 32'h1, side_rdata, side_err);
				check_value("start_in_preload pslverr", 0, side_err);
			end
		join
		wait_idle(busy);
		check_value("busy cycles past sweep", 0, busy);
		apb_access("status_after_run", 1'b0, 8'h04, 32'h0, rdata, err);
		check_value("status after run", 32'h2, rdata);
		end_test();

		begin_test("second_run");
		apb_access("restart", 1'b1, 8'h00, 32'h1, rdata, err);
		fork
			check_preload();
			begin
				apb_access("status_in_preload", 1'b0, 8'h04, 32'h0, side_rdata, side_err);
				check_value("status in preload", 32'h5, side_rdata);
				check_value("status_in_preload pslverr", 0, side_err);
			end
		join
		wait_idle(busy);
		check_value("search busy cycles", SWEEP_LEN, busy);
		apb_access("status_after_rerun", 1'b0, 8'h04, 32'h0, rdata, err);
		check_value("status after rerun", 32'h2, rdata);
		end_test();

		$display("summary: %0d passed, %0d failed, %0d assertion failures", pass_count,
			fail_count, i_ref_mem_ctrl_top.i_tb_ref_mem_ctrl_sva.assert_errors);
		if (fail_count == 0 && i_ref_mem_ctrl_top.i_tb_ref_mem_ctrl_sva.assert_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/ref_bank_pkg.sv
verilog/ref_ctrl_pkg.sv
verilog/ref_apb_regs.sv
verilog/ref_phase_fsm.sv
verilog/ref_preload_gen.sv
verilog/ref_search_rd_gen.sv
verilog/ref_mem_ctrl_top.sv
tb/tb_ref_mem_ctrl_sva.sv
tb/tb_ref_mem_ctrl.sv

// File: Bender.yml
package:
  name: ref_mem_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ref_bank_pkg.sv
      - verilog/ref_ctrl_pkg.sv
      - verilog/ref_apb_regs.sv
      - verilog/ref_phase_fsm.sv
      - verilog/ref_preload_gen.sv
      - verilog/ref_search_rd_gen.sv
      - verilog/ref_mem_ctrl_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - tb/tb_ref_mem_ctrl_sva.sv
      - tb/tb_ref_mem_ctrl.sv
